/* fp64_add_unit.f */
rtl/fp_add_pkg.sv
rtl/fp_pipe_stage.sv
rtl/fp_add_align.sv
rtl/fp_add_sum.sv
rtl/fp_add_round.sv
rtl/fp64_add_unit.sv
bench/fp64_add_unit_checker.sv
bench/fp64_add_unit_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := fp64_add_unit_tb
FLIST      := fp64_add_unit.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only -Wall --timing --assert
SIM_FLAGS  := --binary --timing --assert -Wno-fatal -j 0

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

# A failing run ends in $fatal, which gives a nonzero exit status
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* bench/fp64_add_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fp64_add_unit_tb;

  localparam int TIMEOUT = 1000;
  localparam int NVEC    = 15;
  localparam int NRAND   = 200;

  typedef struct packed {
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] res;
    logic [3:0]  st;
  } vec_t;

  // One operation in flight
  typedef struct packed {
    logic [63:0] res;
    logic [3:0]  st;
    logic        chk_st;
    logic        chk_lat;
    logic [31:0] cyc;
  } entry_t;

  logic                clk_i;
  logic                rst_n_i;
  logic                in_valid_i;
  logic                in_ready_o;
  logic                flush_i;
  fp_add_pkg::fp64_t   a_i;
  fp_add_pkg::fp64_t   b_i;
  fp_add_pkg::fp64_t   result_o;
  fp_add_pkg::status_t status_o;
  logic                out_valid_o;
  logic                out_ready_i;
  logic                busy_o;

  entry_t      sb_q[$];
  string       name_q[$];
  entry_t      cur;
  string       cur_name;
  logic [31:0] cycle_cnt;
  logic [1:0]  ready_mode;
  logic        ready_pat [64];

  // Status column is {nv, of, uf, nx}
  vec_t vec_table [NVEC] = '{
    '{64'h3FF0000000000000, 64'h4000000000000000, 64'h4008000000000000, 4'b0000},
    '{64'h4004000000000000, 64'hBFF0000000000000, 64'h3FF8000000000000, 4'b0000},
    '{64'h3FF0000000000000, 64'hBFF0000000000000, 64'h0000000000000000, 4'b0000},
    '{64'h3FF0000000000000, 64'h3CA0000000000000, 64'h3FF0000000000000, 4'b0001},
    '{64'h3FF0000000000001, 64'h3CA0000000000000, 64'h3FF0000000000002, 4'b0001},
    '{64'h3FF0000000000000, 64'h3CA8000000000000, 64'h3FF0000000000001, 4'b0001},
    '{64'h0000000000000001, 64'h0000000000000002, 64'h0000000000000003, 4'b0000},
    '{64'h000FFFFFFFFFFFFF, 64'h0000000000000001, 64'h0010000000000000, 4'b0000},
    // A sum below the normal range is always exact, so uf stays clear
    '{64'h0010000000000001, 64'h8010000000000000, 64'h0000000000000001, 4'b0000},
    '{64'h7FEFFFFFFFFFFFFF, 64'h7FEFFFFFFFFFFFFF, 64'h7FF0000000000000, 4'b0101},
    '{64'h7FF0000000000000, 64'hFFF0000000000000, 64'h7FF8000000000000, 4'b1000},
    '{64'h7FF8000000000000, 64'h3FF0000000000000, 64'h7FF8000000000000, 4'b0000},
    '{64'h3FF0000000000000, 64'h7FF0000000000001, 64'h7FF8000000000000, 4'b1000},
    '{64'hFFF0000000000000, 64'h3FF0000000000000, 64'hFFF0000000000000, 4'b0000},
    '{64'h8000000000000000, 64'h8000000000000000, 64'h8000000000000000, 4'b0000}
  };
  string vec_name [NVEC] = '{
    "add_one_two", "add_mixed_sign", "cancel_to_zero", "tie_even_down", "tie_even_up",
    "round_above_half", "sub_plus_sub", "sub_to_normal", "tiny_exact", "max_overflow",
    "inf_minus_inf", "qnan_operand", "snan_operand", "inf_plus_finite", "neg_zero_sum"
  };

  fp64_add_unit dut0 (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .flush_i     (flush_i),
    .a_i         (a_i),
    .b_i         (b_i),
    .result_o    (result_o),
    .status_o    (status_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .busy_o      (busy_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("[FAIL] %s expected %h actual %h", name, expected, actual));
    end
  endtask

  // Output back-pressure: 0 always ready, 1 random pattern, 2 stalled
  initial begin : ready_drive
    int         idx;
    logic [1:0] mode;
    idx         = 0;
    out_ready_i = 1'b1;
    forever begin
      @(posedge clk_i);
      mode = ready_mode;
      #1;
      case (mode)
        2'd0:    out_ready_i = 1'b1;
        2'd1:    out_ready_i = ready_pat[idx % 64];
        default: out_ready_i = 1'b0;
      endcase
      idx++;
    end
  end

  // Scoreboard, sampled mid-cycle where every signal has settled
  always @(negedge clk_i) begin : monitor
    entry_t e;
    string  n;
    if (!rst_n_i) begin
      cycle_cnt = '0;
    end else if (flush_i) begin
      sb_q.delete();
      name_q.delete();
    end else begin
      if (!in_ready_o) begin
        check_value("in_ready_low_only_when_full", 64'd3, 64'(sb_q.size()));
      end
      if (out_valid_o && out_ready_i) begin
        if (sb_q.size() == 0) begin
          abort_run("a result came out with no operation in flight");
        end else begin
          e = sb_q.pop_front();
          n = name_q.pop_front();
          check_value({n, "_result"}, e.res, result_o);
          if (e.chk_st) begin
            check_value({n, "_status"}, 64'(e.st), 64'(status_o));
          end
          if (e.chk_lat) begin
            check_value({n, "_latency"}, 64'd3, 64'(cycle_cnt - e.cyc));
          end
        end
      end
      if (in_valid_i && in_ready_o) begin
        e     = cur;
        e.cyc = cycle_cnt;
        sb_q.push_back(e);
        name_q.push_back(cur_name);
      end
    end
    cycle_cnt = cycle_cnt + 32'd1;
  end

  task automatic send_op(input string name, input logic [63:0] a, input logic [63:0] b,
                         input logic [63:0] res, input logic [3:0] st,
                         input logic chk_st, input logic chk_lat);
    int   waited;
    logic taken;
    waited     = 0;
    taken      = 1'b0;
    a_i        = a;
    b_i        = b;
    cur        = '{res: res, st: st, chk_st: chk_st, chk_lat: chk_lat, cyc: '0};
    cur_name   = name;
    in_valid_i = 1'b1;
    while (!taken) begin
      @(negedge clk_i);
      taken = in_ready_o;
      @(posedge clk_i);
      #1;
      waited++;
      if (!taken && waited >= TIMEOUT) begin
        abort_run($sformatf("%s was never accepted by the adder", name));
      end
    end
    in_valid_i = 1'b0;
  endtask

  task automatic send_table(input int count, input logic chk_lat);
    for (int i = 0; i < count; i++) begin
      send_op(vec_name[i], vec_table[i].a, vec_table[i].b, vec_table[i].res,
              vec_table[i].st, 1'b1, chk_lat);
    end
  endtask

  // Exponent near the bias keeps sums clear of overflow and the subnormal range
  function automatic logic [63:0] random_normal();
    logic [63:0] v;
    v        = {$urandom, $urandom};
    v[62:52] = 11'(1000 + $urandom_range(46, 0));
    return v;
  endfunction

  task automatic send_random(input int count);
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] sum;
    for (int i = 0; i < count; i++) begin
      a   = random_normal();
      b   = random_normal();
      sum = $realtobits($bitstoreal(a) + $bitstoreal(b));
      send_op($sformatf("random_%0d", i), a, b, sum, 4'b0000, 1'b0, 1'b0);
    end
  endtask

  task automatic drain_pipe();
    int waited;
    waited = 0;
    while (sb_q.size() != 0 || busy_o) begin
      @(posedge clk_i);
      #1;
      waited++;
      if (waited >= TIMEOUT) begin
        abort_run("pipeline did not drain in time");
      end
    end
  endtask

  initial begin : main
    void'($urandom(32'h54b95933));
    rst_n_i    = 1'b0;
    in_valid_i = 1'b0;
    flush_i    = 1'b0;
    a_i        = '0;
    b_i        = '0;
    ready_mode = 2'd0;
    cur        = '0;
    cur_name   = "";
    for (int i = 0; i < 64; i++) begin
      ready_pat[i] = 1'($urandom_range(1, 0));
    end
    repeat (3) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    check_value("reset_out_valid", 64'd0, 64'(out_valid_o));
    check_value("reset_busy", 64'd0, 64'(busy_o));
    check_value("reset_in_ready", 64'd1, 64'(in_ready_o));

    // Back to back with the output always ready
    send_table(NVEC, 1'b1);
    drain_pipe();

    // Random back-pressure
    ready_mode = 2'd1;
    send_random(NRAND);
    send_table(NVEC, 1'b0);
    drain_pipe();

    // Fill all three stages behind a stalled output, then flush
    ready_mode = 2'd2;
    send_table(3, 1'b0);
    check_value("flush_busy_before", 64'd1, 64'(busy_o));
    flush_i = 1'b1;
    @(posedge clk_i);
    #1;
    flush_i = 1'b0;
    check_value("flush_busy_after", 64'd0, 64'(busy_o));
    check_value("flush_out_valid_after", 64'd0, 64'(out_valid_o));
    ready_mode = 2'd0;
    send_table(NVEC, 1'b1);
    drain_pipe();

    if (dut0.u_checker.assert_fails == 0) begin
      $display("Test passed");
      $finish;
    end else begin
      abort_run("handshake assertions failed in the checker");
    end
  end

endmodule

`default_nettype wire

/* bench/fp64_add_unit_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module fp64_add_unit_checker (
  input logic              clk_i,
  input logic              rst_n_i,
  input logic              flush_i,
  input logic              in_valid_i,
  input logic              in_ready_o,
  input logic              out_valid_o,
  input logic              out_ready_i,
  input logic              busy_o,
  input fp_add_pkg::fp64_t result_o
);

  // Failed assertion count
  int unsigned assert_fails = 0;

  // A stalled result holds until taken
  property result_held;
    @(posedge clk_i) disable iff (!rst_n_i)
      out_valid_o && !out_ready_i && !flush_i |=> out_valid_o && $stable(result_o);
  endproperty

  property flush_empties;
    @(posedge clk_i) disable iff (!rst_n_i)
      flush_i |=> !out_valid_o;
  endproperty

  // Busy while a result waits and in the cycle after an accepted operation
  property busy_covers_items;
    @(posedge clk_i) disable iff (!rst_n_i)
      out_valid_o || $past(rst_n_i && in_valid_i && in_ready_o && !flush_i) |-> busy_o;
  endproperty

  result_held_a: assert property (result_held) else begin
    assert_fails++;
    $error("result changed or vanished while the output was stalled");
  end

  flush_empties_a: assert property (flush_empties) else begin
    assert_fails++;
    $error("output still valid in the cycle after a flush");
  end

  busy_covers_items_a: assert property (busy_covers_items) else begin
    assert_fails++;
    $error("busy low while an operation is held");
  end

endmodule

bind fp64_add_unit fp64_add_unit_checker u_checker (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .flush_i     (flush_i),
  .in_valid_i  (in_valid_i),
  .in_ready_o  (in_ready_o),
  .out_valid_o (out_valid_o),
  .out_ready_i (out_ready_i),
  .busy_o      (busy_o),
  .result_o    (result_o)
);

`default_nettype wire

/* rtl/fp64_add_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fp64_add_unit (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Input handshake
  input  logic                in_valid_i,
  output logic                in_ready_o,
  input  logic                flush_i,
  input  fp_add_pkg::fp64_t   a_i,
  input  fp_add_pkg::fp64_t   b_i,
  // Result
  output fp_add_pkg::fp64_t   result_o,
  output fp_add_pkg::status_t status_o,
  // Output handshake
  output logic                out_valid_o,
  input  logic                out_ready_i,
  // Something still in flight
  output logic                busy_o
);

  fp_add_pkg::align_pl_t align_pl;
  fp_add_pkg::align_pl_t s1_pl;
  fp_add_pkg::sum_pl_t   sum_pl;
  fp_add_pkg::sum_pl_t   s2_pl;
  fp_add_pkg::out_pl_t   round_pl;
  fp_add_pkg::out_pl_t   s3_pl;

  logic s1_valid, s2_valid;
  logic s2_ready, s3_ready;

  fp_add_align u_align (
    .a_i  (a_i),
    .b_i  (b_i),
    .pl_o (align_pl)
  );

  fp_pipe_stage #(.payload_t(fp_add_pkg::align_pl_t)) u_s1 (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .flush_i   (flush_i),
    .valid_i   (in_valid_i),
    .ready_o   (in_ready_o),
    .payload_i (align_pl),
    .valid_o   (s1_valid),
    .ready_i   (s2_ready),
    .payload_o (s1_pl)
  );

  fp_add_sum u_sum (
    .pl_i (s1_pl),
    .pl_o (sum_pl)
  );

  fp_pipe_stage #(.payload_t(fp_add_pkg::sum_pl_t)) u_s2 (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .flush_i   (flush_i),
    .valid_i   (s1_valid),
    .ready_o   (s2_ready),
    .payload_i (sum_pl),
    .valid_o   (s2_valid),
    .ready_i   (s3_ready),
    .payload_o (s2_pl)
  );

  fp_add_round u_round (
    .pl_i (s2_pl),
    .pl_o (round_pl)
  );

  // Last stage drives the outputs directly
  fp_pipe_stage #(.payload_t(fp_add_pkg::out_pl_t)) u_s3 (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .flush_i   (flush_i),
    .valid_i   (s2_valid),
    .ready_o   (s3_ready),
    .payload_i (round_pl),
    .valid_o   (out_valid_o),
    .ready_i   (out_ready_i),
    .payload_o (s3_pl)
  );

  assign result_o = s3_pl.result;
  assign status_o = s3_pl.status;
  assign busy_o   = s1_valid | s2_valid | out_valid_o;

endmodule

`default_nettype wire

/* rtl/fp_add_round.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_add_round (
  input  fp_add_pkg::sum_pl_t pl_i,
  output fp_add_pkg::out_pl_t pl_o
);

  localparam int EW = fp_add_pkg::EXP_BITS;
  localparam int MW = fp_add_pkg::MAN_BITS;
  localparam int SW = fp_add_pkg::SIG_BITS;
  localparam int AW = fp_add_pkg::ASIG_BITS;
  localparam int NW = fp_add_pkg::NEXP_BITS;

  logic                 lsb, grd, rnd, stk;
  logic                 inexact;
  logic                 round_up;
  logic                 tiny;
  logic [SW:0]          rounded;
  logic signed [NW-1:0] exp_r;
  logic [MW-1:0]        man_r;
  logic                 hidden;
  logic [EW-1:0]        exp_field;
  logic                 overflow;

  // Rounding bits below the kept significand
  assign lsb = pl_i.sig[3];
  assign grd = pl_i.sig[2];
  assign rnd = pl_i.sig[1];
  assign stk = pl_i.sig[0];

  assign inexact  = grd | rnd | stk;
  // Nearest even, ties go to even lsb
  assign round_up = grd & (rnd | stk | lsb);
  // No hidden bit before rounding means subnormal range
  assign tiny     = ~pl_i.sig[AW-1];

  assign rounded = {1'b0, pl_i.sig[AW-1:3]} + {{SW{1'b0}}, round_up};

  always_comb begin
    if (rounded[SW]) begin
      // Rounded up past the hidden bit
      exp_r = pl_i.exp + NW'(1);
      man_r = rounded[SW-1:1];
    end else begin
      exp_r = pl_i.exp;
      man_r = rounded[MW-1:0];
    end
  end

  // A subnormal may round up into the smallest normal
  assign hidden    = rounded[SW] | rounded[SW-1];
  assign exp_field = hidden ? exp_r[EW-1:0] : '0;
  assign overflow  = (exp_r >= fp_add_pkg::EXP_MAX);

  always_comb begin
    pl_o.status    = '0;
    pl_o.status.nv = pl_i.nv;
    case (pl_i.special)
      fp_add_pkg::SP_NAN: begin
        pl_o.result = fp_add_pkg::QNAN;
      end
      fp_add_pkg::SP_INF: begin
        pl_o.result = '{sign: pl_i.special_sign, exponent: '1, mantissa: '0};
      end
      fp_add_pkg::SP_ZERO: begin
        pl_o.result = '{sign: pl_i.special_sign, exponent: '0, mantissa: '0};
      end
      default: begin
        if (overflow) begin
          pl_o.result    = '{sign: pl_i.sign, exponent: '1, mantissa: '0};
          pl_o.status.of = 1'b1;
          pl_o.status.nx = 1'b1;
        end else begin
          pl_o.result    = '{sign: pl_i.sign, exponent: exp_field, mantissa: man_r};
          pl_o.status.nx = inexact;
          pl_o.status.uf = tiny & inexact;
        end
      end
    endcase
  end

endmodule

`default_nettype wire

/* rtl/fp_add_sum.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_add_sum (
  input  fp_add_pkg::align_pl_t pl_i,
  output fp_add_pkg::sum_pl_t   pl_o
);

  localparam int EW = fp_add_pkg::EXP_BITS;
  localparam int AW = fp_add_pkg::ASIG_BITS;
  localparam int NW = fp_add_pkg::NEXP_BITS;
  localparam int LW = $clog2(AW + 1);

  logic [AW:0]          raw;
  logic [LW-1:0]        lzc;
  logic [EW-1:0]        shift_limit;
  logic [LW-1:0]        shamt;
  logic [AW-1:0]        norm_sig;
  logic signed [NW-1:0] norm_exp;

  function automatic logic [LW-1:0] count_lz(input logic [AW-1:0] v);
    logic          found;
    logic [LW-1:0] n;
    found = 1'b0;
    n     = '0;
    for (int i = AW - 1; i >= 0; i--) begin
      if (!found) begin
        if (v[i]) begin
          found = 1'b1;
        end else begin
          n = n + 1'b1;
        end
      end
    end
    return n;
  endfunction

  // Larger magnitude is always first, so the difference never goes negative
  assign raw = pl_i.eff_sub ? ({1'b0, pl_i.sig_big} - {1'b0, pl_i.sig_small})
                            : ({1'b0, pl_i.sig_big} + {1'b0, pl_i.sig_small});

  assign lzc = count_lz(raw[AW-1:0]);

  // Stop the left shift at exponent 1 so subnormals stay subnormal
  assign shift_limit = pl_i.exp - EW'(1);
  assign shamt       = ({{(EW-LW){1'b0}}, lzc} <= shift_limit) ? lzc : shift_limit[LW-1:0];

  always_comb begin
    if (raw[AW]) begin
      // Carry out, fold the dropped bit into sticky
      norm_sig = {raw[AW:2], raw[1] | raw[0]};
      norm_exp = {2'b00, pl_i.exp} + NW'(1);
    end else begin
      norm_sig = raw[AW-1:0] << shamt;
      norm_exp = {2'b00, pl_i.exp} - NW'(shamt);
    end
  end

  always_comb begin
    pl_o.sign         = pl_i.sign;
    pl_o.exp          = norm_exp;
    pl_o.sig          = norm_sig;
    pl_o.special      = pl_i.special;
    pl_o.special_sign = pl_i.special_sign;
    pl_o.nv           = pl_i.nv;
    // Exact cancellation is +0 under round to nearest
    if (pl_i.special == fp_add_pkg::SP_NONE && raw == '0) begin
      pl_o.special      = fp_add_pkg::SP_ZERO;
      pl_o.special_sign = 1'b0;
    end
  end

endmodule

`default_nettype wire

/* rtl/fp_add_align.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_add_align (
  input  fp_add_pkg::fp64_t     a_i,
  input  fp_add_pkg::fp64_t     b_i,
  output fp_add_pkg::align_pl_t pl_o
);

  localparam int EW  = fp_add_pkg::EXP_BITS;
  localparam int SW  = fp_add_pkg::SIG_BITS;
  localparam int AW  = fp_add_pkg::ASIG_BITS;
  // Room below the aligned significand to catch shifted-out bits
  localparam int SHW = AW + 64;

  logic                 a_exp_max, b_exp_max;
  logic                 a_nan, b_nan, a_snan, b_snan;
  logic                 a_inf, b_inf, a_zero, b_zero;
  logic [EW-1:0]        a_exp, b_exp;
  logic [SW-1:0]        a_sig, b_sig;
  logic                 a_big;
  logic [EW-1:0]        big_exp, small_exp, exp_diff;
  logic [SW-1:0]        big_sig, small_sig;
  logic [5:0]           shamt;
  logic [SHW-1:0]       shift_wide;
  logic [AW-1:0]        small_aligned;
  fp_add_pkg::special_e special;
  logic                 special_sign;
  logic                 nv;

  // Field classification
  assign a_exp_max = (a_i.exponent == EW'(fp_add_pkg::EXP_MAX));
  assign b_exp_max = (b_i.exponent == EW'(fp_add_pkg::EXP_MAX));
  assign a_nan     = a_exp_max && (a_i.mantissa != '0);
  assign b_nan     = b_exp_max && (b_i.mantissa != '0);
  // Quiet bit clear means signalling
  assign a_snan    = a_nan && !a_i.mantissa[fp_add_pkg::MAN_BITS-1];
  assign b_snan    = b_nan && !b_i.mantissa[fp_add_pkg::MAN_BITS-1];
  assign a_inf     = a_exp_max && (a_i.mantissa == '0);
  assign b_inf     = b_exp_max && (b_i.mantissa == '0);
  assign a_zero    = (a_i.exponent == '0) && (a_i.mantissa == '0);
  assign b_zero    = (b_i.exponent == '0) && (b_i.mantissa == '0);

  // Subnormals sit at exponent 1 without the hidden bit
  assign a_exp = (a_i.exponent == '0) ? EW'(1) : a_i.exponent;
  assign b_exp = (b_i.exponent == '0) ? EW'(1) : b_i.exponent;
  assign a_sig = {(a_i.exponent != '0), a_i.mantissa};
  assign b_sig = {(b_i.exponent != '0), b_i.mantissa};

  always_comb begin
    special      = fp_add_pkg::SP_NONE;
    special_sign = 1'b0;
    nv           = a_snan | b_snan;
    if (a_nan || b_nan) begin
      special = fp_add_pkg::SP_NAN;
    end else if (a_inf && b_inf && (a_i.sign != b_i.sign)) begin
      special = fp_add_pkg::SP_NAN;
      nv      = 1'b1;
    end else if (a_inf || b_inf) begin
      special      = fp_add_pkg::SP_INF;
      special_sign = a_inf ? a_i.sign : b_i.sign;
    end else if (a_zero && b_zero) begin
      // -0 only when both are -0
      special      = fp_add_pkg::SP_ZERO;
      special_sign = a_i.sign & b_i.sign;
    end
  end

  // Magnitude compare on exponent and mantissa together
  assign a_big     = {a_i.exponent, a_i.mantissa} >= {b_i.exponent, b_i.mantissa};
  assign big_exp   = a_big ? a_exp : b_exp;
  assign small_exp = a_big ? b_exp : a_exp;
  assign big_sig   = a_big ? a_sig : b_sig;
  assign small_sig = a_big ? b_sig : a_sig;
  assign exp_diff  = big_exp - small_exp;

  // Beyond 63 everything lands in sticky anyway
  assign shamt      = (exp_diff > EW'(63)) ? 6'd63 : exp_diff[5:0];
  assign shift_wide = {small_sig, 3'b000, 64'b0} >> shamt;
  assign small_aligned = {shift_wide[SHW-1:65], shift_wide[64] | (|shift_wide[63:0])};

  always_comb begin
    pl_o.sign         = a_big ? a_i.sign : b_i.sign;
    pl_o.eff_sub      = a_i.sign ^ b_i.sign;
    pl_o.exp          = big_exp;
    pl_o.sig_big      = {big_sig, 3'b000};
    pl_o.sig_small    = small_aligned;
    pl_o.special      = special;
    pl_o.special_sign = special_sign;
    pl_o.nv           = nv;
  end

endmodule

`default_nettype wire

/* rtl/fp_pipe_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     flush_i,
  // Upstream side
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t payload_i,
  // Downstream side
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t payload_o
);

  logic     valid_q;
  payload_t payload_q;

  // Take a new item when empty or when the held one leaves this cycle
  assign ready_o = ~valid_q | ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // Payload only moves on acceptance
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      payload_q <= payload_i;
    end
  end

  assign valid_o   = valid_q;
  assign payload_o = payload_q;

endmodule

`default_nettype wire

/* rtl/fp_add_pkg.sv */
`default_nettype none

package fp_add_pkg;

  // FP64 field layout
  localparam int EXP_BITS = 11;
  localparam int MAN_BITS = 52;
  localparam int BIAS     = 1023;

  // All-ones exponent used by infinity and NaN
  localparam int EXP_MAX = 2 * BIAS + 1;

  // Significand with hidden bit
  localparam int SIG_BITS = MAN_BITS + 1;
  // Aligned significand, hidden bit down to guard, round and sticky
  localparam int ASIG_BITS = SIG_BITS + 3;
  // Normalized exponent with headroom for carry and sign
  localparam int NEXP_BITS = EXP_BITS + 2;

  typedef struct packed {
    logic                sign;
    logic [EXP_BITS-1:0] exponent;
    logic [MAN_BITS-1:0] mantissa;
  } fp64_t;

  typedef struct packed {
    logic nv;
    logic of;
    logic uf;
    logic nx;
  } status_t;

  typedef enum logic [1:0] {
    SP_NONE,
    SP_NAN,
    SP_INF,
    SP_ZERO
  } special_e;

  // Canonical quiet NaN
  localparam fp64_t QNAN = '{
    sign:     1'b0,
    exponent: '1,
    mantissa: {1'b1, {(MAN_BITS-1){1'b0}}}
  };

  typedef struct packed {
    logic                 sign;
    logic                 eff_sub;
    logic [EXP_BITS-1:0]  exp;
    logic [ASIG_BITS-1:0] sig_big;
    logic [ASIG_BITS-1:0] sig_small;
    special_e             special;
    logic                 special_sign;
    logic                 nv;
  } align_pl_t;

  typedef struct packed {
    logic                        sign;
    logic signed [NEXP_BITS-1:0] exp;
    logic [ASIG_BITS-1:0]        sig;
    special_e                    special;
    logic                        special_sign;
    logic                        nv;
  } sum_pl_t;

  typedef struct packed {
    fp64_t   result;
    status_t status;
  } out_pl_t;

endpackage

`default_nettype wire
